/* hbm_trace.txt */
# columns: kind (W or R), channel, byte address (hex), data (hex)
# for R the data column is the word the read must return
W 0 010 11110000
W 1 010 22220000
R 0 010 11110000
R 1 010 22220000
R 0 024 00000000
R 1 024 00000000
W 0 0a0 a0a0a0a0
W 1 104 12345678
W 0 1a0 a1a1a1a1
R 1 104 12345678
R 0 0a3 a0a0a0a0
W 1 ffc deadbeef
R 0 1a0 a1a1a1a1
R 1 ffc deadbeef
W 0 2c4 c2c2c2c2
W 1 104 87654321
W 0 5c8 c5c5c5c5
R 1 106 87654321
R 1 0ff 00000000
R 0 0c0 00000000
R 0 1c0 00000000
R 0 2c4 c2c2c2c2
R 0 3c0 00000000
R 0 4c0 00000000
R 0 5c8 c5c5c5c5
R 0 6c0 00000000
R 0 7c0 00000000
R 0 8c0 00000000
R 0 9c0 00000000
R 0 010 11110000

/* src.f */
+incdir+.
hbm_addr_pkg.sv
hbm_req_pkg.sv
hbm_cmd_queue.sv
hbm_bank_timing.sv
hbm_channel_store.sv
hbm_model.sv
hbm_clock_gen.sv
hbm_model_tb.sv

/* Makefile */
SIM = obj_dir/Vhbm_model_tb
SRCS = $(wildcard *.sv *.svh) src.f

.PHONY: all run clean

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert --top-module hbm_model_tb -Mdir obj_dir -f src.f

run: $(SIM) hbm_trace.txt
	./$(SIM) | tee sim.log
	grep -q "^SIMULATION PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* hbm_model_tb.sv */
`include "hbm_config.svh"

module hbm_model_tb;
  import hbm_addr_pkg::*;
  import hbm_req_pkg::*;

  localparam int num_ch = `HBM_NUM_CHANNELS;

  typedef struct packed {
    logic write_not_read;
    int chan;
    hbm_ch_addr_t addr;
    hbm_word_t data;
    logic [1:0] gap;
    logic [1:0] data_delay;
  } trace_line_t;

  typedef struct packed {
    hbm_ch_addr_t addr;
    hbm_word_t data;
  } expect_t;

  logic clk;
  logic reset;
  logic [num_ch-1:0] req_v;
  logic [num_ch-1:0] yumi;
  logic [num_ch-1:0] wdata_v;
  logic [num_ch-1:0] wdata_yumi;
  logic [num_ch-1:0] resp_v;
  logic [num_ch-1:0] chan_idle;
  hbm_req_t [num_ch-1:0] req;
  hbm_word_t [num_ch-1:0] wdata;
  hbm_word_t [num_ch-1:0] resp_data;
  hbm_ch_addr_t [num_ch-1:0] resp_addr;
  trace_line_t trace_q [$];
  logic trace_loaded = 1'b0;
  int timeout_cycles = 0;
  int cycle_count = 0;

  hbm_clock_gen clock_gen (
    .clk_o(clk),
    .reset_o(reset)
  );

  hbm_model hbm_model_inst (
    .clk_i(clk),
    .reset_i(reset),
    .v_i(req_v),
    .req_i(req),
    .yumi_o(yumi),
    .data_v_i(wdata_v),
    .data_i(wdata),
    .data_yumi_o(wdata_yumi),
    .data_v_o(resp_v),
    .data_o(resp_data),
    .ch_addr_o(resp_addr)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    abort_run();
  endtask

  function automatic hbm_ch_addr_t word_aligned(hbm_ch_addr_t addr);
    return addr & ~hbm_ch_addr_t'(`HBM_DATA_WIDTH / 8 - 1);
  endfunction

  // gaps and data delays drawn in file order
  task automatic load_trace();
    int fd;
    string text;
    byte kind;
    int chan;
    logic [31:0] addr;
    logic [31:0] data;
    trace_line_t line;
    fd = $fopen("hbm_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file hbm_trace.txt");
      abort_run();
    end
    while ($fgets(text, fd) > 0) begin
      if (text.len() < 2 || text.getc(0) == "#") continue;
      if ($sscanf(text, "%c %d %h %h", kind, chan, addr, data) != 4 || chan >= num_ch) begin
        $display("trace line could not be parsed: %s", text);
        abort_run();
      end
      line.write_not_read = (kind == "W");
      line.chan = chan;
      line.addr = hbm_ch_addr_t'(addr);
      line.data = data;
      line.gap = 2'($urandom % 4);
      line.data_delay = 2'($urandom % 3);
      trace_q.push_back(line);
    end
    $fclose(fd);
  endtask

  for (genvar c = 0; c < num_ch; c++) begin : gen_feed
    logic ch_v;
    hbm_req_t ch_req;
    logic ch_data_v;
    hbm_word_t ch_data;
    logic feed_done;
    logic idle;
    int stalls;
    expect_t exp_q [$];

    assign req_v[c] = ch_v;
    assign req[c] = ch_req;
    assign wdata_v[c] = ch_data_v;
    assign wdata[c] = ch_data;
    assign chan_idle[c] = idle;

    // one request at a time held until yumi
    initial begin
      int wait_cycles;
      logic accepted;
      ch_v = 1'b0;
      ch_req = '0;
      ch_data_v = 1'b0;
      ch_data = '0;
      feed_done = 1'b0;
      stalls = 0;
      wait (trace_loaded && !reset);
      @(negedge clk);
      foreach (trace_q[i]) begin
        if (trace_q[i].chan == c) begin
          repeat (trace_q[i].gap) @(negedge clk);
          ch_v = 1'b1;
          ch_req = '{trace_q[i].write_not_read, trace_q[i].addr};
          ch_data = trace_q[i].write_not_read ? trace_q[i].data : '0;
          wait_cycles = ch_req.write_not_read ? int'(trace_q[i].data_delay) : 0;
          ch_data_v = ch_req.write_not_read && wait_cycles == 0;
          accepted = 1'b0;
          while (!accepted) begin
            // yumi has settled and inputs stay put until the next falling edge
            #1;
            if (ch_req.write_not_read && !ch_data_v) begin
              assert (!yumi[c] && !wdata_yumi[c])
                else report_mismatch($sformatf("ch %0d write acknowledged without data", c));
            end else begin
              assert (wdata_yumi[c] == (yumi[c] && ch_req.write_not_read))
                else report_mismatch($sformatf("ch %0d data_yumi_o does not match yumi_o", c));
              accepted = yumi[c];
              if (!yumi[c]) begin
                stalls++;
              end
            end
            if (accepted && !ch_req.write_not_read) begin
              exp_q.push_back('{word_aligned(ch_req.ch_addr), trace_q[i].data});
            end
            @(negedge clk);
            if (wait_cycles > 0) begin
              wait_cycles--;
              ch_data_v = (wait_cycles == 0);
            end
          end
          ch_v = 1'b0;
          ch_data_v = 1'b0;
        end
      end
      feed_done = 1'b1;
    end

    // responses in request order
    always @(negedge clk) begin
      expect_t expected;
      if (resp_v[c]) begin
        assert (exp_q.size() > 0)
          else report_mismatch($sformatf("ch %0d response with no read outstanding", c));
        expected = exp_q.pop_front();
        assert (resp_addr[c] == expected.addr)
          else report_mismatch($sformatf("ch %0d ch_addr_o %h, expected %h",
                                         c, resp_addr[c], expected.addr));
        assert (resp_data[c] == expected.data)
          else report_mismatch($sformatf("ch %0d data_o %h at %h, expected %h",
                                         c, resp_data[c], expected.addr, expected.data));
      end
    end

    always @(posedge clk) begin
      idle <= feed_done && exp_q.size() == 0;
    end
  end

  always @(posedge clk) begin
    if (trace_loaded) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
        $display("timeout after %0d cycles, responses never arrived", cycle_count);
        abort_run();
      end
    end
  end

  initial begin
    void'($urandom(78));
    load_trace();
    timeout_cycles = trace_q.size() * (`HBM_T_MISS + 8) + 100;
    trace_loaded = 1'b1;
    wait (&chan_idle);
    // stray responses still get caught by the checkers
    repeat (4) @(negedge clk);
    // row-miss burst on channel 0 outruns its queue
    assert (gen_feed[0].stalls > 0)
      else report_mismatch("channel 0 never saw yumi_o held low by a full queue");
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* hbm_clock_gen.sv */
module hbm_clock_gen #(
  parameter int half_period_p = 4,
  parameter int reset_cycles_p = 3
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(half_period_p) clk_o = ~clk_o;
  end

  // release on a falling edge, clear of the sampling edge
  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

/* hbm_model.sv */
`include "hbm_config.svh"

module hbm_model (
  input  logic                                               clk_i,
  input  logic                                               reset_i,

  input  logic [`HBM_NUM_CHANNELS-1:0]                       v_i,
  input  hbm_req_pkg::hbm_req_t [`HBM_NUM_CHANNELS-1:0]      req_i,
  output logic [`HBM_NUM_CHANNELS-1:0]                       yumi_o,

  input  logic [`HBM_NUM_CHANNELS-1:0]                       data_v_i,
  input  hbm_addr_pkg::hbm_word_t [`HBM_NUM_CHANNELS-1:0]    data_i,
  output logic [`HBM_NUM_CHANNELS-1:0]                       data_yumi_o,

  output logic [`HBM_NUM_CHANNELS-1:0]                       data_v_o,
  output hbm_addr_pkg::hbm_word_t [`HBM_NUM_CHANNELS-1:0]    data_o,
  output hbm_addr_pkg::hbm_ch_addr_t [`HBM_NUM_CHANNELS-1:0] ch_addr_o
);
  import hbm_addr_pkg::*;
  import hbm_req_pkg::*;

  logic [`HBM_NUM_CHANNELS-1:0] done_v;
  hbm_done_t [`HBM_NUM_CHANNELS-1:0] done;

  // channels share nothing
  for (genvar c = 0; c < `HBM_NUM_CHANNELS; c++) begin : gen_channel

    hbm_bank_timing bank_timing (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .channel_id_i(hbm_chan_t'(c)),
      .v_i(v_i[c]),
      .req_i(req_i[c]),
      .data_v_i(data_v_i[c]),
      .data_i(data_i[c]),
      .yumi_o(yumi_o[c]),
      .data_yumi_o(data_yumi_o[c]),
      .done_v_o(done_v[c]),
      .done_o(done[c])
    );

    hbm_channel_store store (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .done_v_i(done_v[c]),
      .done_i(done[c]),
      .data_v_o(data_v_o[c]),
      .data_o(data_o[c]),
      .ch_addr_o(ch_addr_o[c])
    );

  end

endmodule

/* hbm_channel_store.sv */
`include "hbm_config.svh"

module hbm_channel_store (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        done_v_i,
  input  hbm_req_pkg::hbm_done_t      done_i,
  output logic                        data_v_o,
  output hbm_addr_pkg::hbm_word_t     data_o,
  output hbm_addr_pkg::hbm_ch_addr_t  ch_addr_o
);
  import hbm_addr_pkg::*;

  localparam int num_words = 2 ** word_addr_width;

  hbm_word_t mem_r [num_words];
  logic [word_addr_width-1:0] word_addr;
  logic data_v_r;
  hbm_word_t data_r;
  hbm_ch_addr_t ch_addr_r;

  assign word_addr = done_i.ch_addr[`HBM_CH_ADDR_WIDTH-1:byte_off_width];

  // never-written words read back as zero
  initial begin
    for (int i = 0; i < num_words; i++) begin
      mem_r[i] = '0;
    end
  end

  always @(posedge clk_i) begin
    if (done_v_i && done_i.write_not_read) begin
      mem_r[word_addr] <= done_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_v_r <= 1'b0;
    end else begin
      data_v_r <= done_v_i & ~done_i.write_not_read;
    end
  end

  // read word and its address, one cycle after completion
  always_ff @(posedge clk_i) begin
    if (done_v_i && !done_i.write_not_read) begin
      data_r <= mem_r[word_addr];
      ch_addr_r <= done_i.ch_addr;
    end
  end

  assign data_v_o = data_v_r;
  assign data_o = data_r;
  assign ch_addr_o = ch_addr_r;

endmodule

/* hbm_bank_timing.sv */
`include "hbm_config.svh"

module hbm_bank_timing (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  hbm_addr_pkg::hbm_chan_t  channel_id_i,
  input  logic                     v_i,
  input  hbm_req_pkg::hbm_req_t    req_i,
  input  logic                     data_v_i,
  input  hbm_addr_pkg::hbm_word_t  data_i,
  output logic                     yumi_o,
  output logic                     data_yumi_o,
  output logic                     done_v_o,
  output hbm_req_pkg::hbm_done_t   done_o
);
  import hbm_addr_pkg::*;
  import hbm_req_pkg::*;

  localparam int lat_width = $clog2(`HBM_T_MISS);

  hbm_mem_addr_t mem_addr;
  hbm_cmd_t push_cmd;
  hbm_cmd_t head_cmd;
  hbm_cmd_t cur_cmd_r;
  logic full;
  logic head_v;
  logic start;
  logic row_hit;

  logic busy_r;
  logic [lat_width-1:0] count_r;
  hbm_row_t open_row_r [`HBM_NUM_BANKS];
  logic [`HBM_NUM_BANKS-1:0] open_v_r;

  // split the channel address and insert the channel index
  assign mem_addr.row = req_i.ch_addr[`HBM_CH_ADDR_WIDTH-1 -: row_width];
  assign mem_addr.bank = req_i.ch_addr[byte_off_width+col_width +: bank_width];
  assign mem_addr.chan = channel_id_i;
  assign mem_addr.col = req_i.ch_addr[byte_off_width +: col_width];
  assign mem_addr.offset = req_i.ch_addr[byte_off_width-1:0];

  // a write only goes in together with its data
  assign yumi_o = v_i & ~full & (~req_i.write_not_read | data_v_i);
  assign data_yumi_o = yumi_o & req_i.write_not_read;

  assign push_cmd.write_not_read = req_i.write_not_read;
  assign push_cmd.mem_addr = mem_addr;
  assign push_cmd.data = req_i.write_not_read ? data_i : '0;

  hbm_cmd_queue #(
    .depth_p(`HBM_QUEUE_DEPTH)
  ) cmd_queue (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .push_i(yumi_o),
    .push_cmd_i(push_cmd),
    .full_o(full),
    .pop_i(start),
    .head_v_o(head_v),
    .head_cmd_o(head_cmd)
  );

  // next command starts only after the open row is updated
  assign start = head_v & ~busy_r;
  assign row_hit = open_v_r[head_cmd.mem_addr.bank]
                   && (open_row_r[head_cmd.mem_addr.bank] == head_cmd.mem_addr.row);

  assign done_v_o = busy_r & (count_r == '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      count_r <= '0;
      open_v_r <= '0;
    end else begin
      if (start) begin
        busy_r <= 1'b1;
        count_r <= row_hit ? lat_width'(`HBM_T_HIT - 1) : lat_width'(`HBM_T_MISS - 1);
      end else if (done_v_o) begin
        busy_r <= 1'b0;
      end else if (busy_r) begin
        count_r <= count_r - 1'b1;
      end
      if (done_v_o) begin
        open_v_r[cur_cmd_r.mem_addr.bank] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      cur_cmd_r <= head_cmd;
    end
    if (done_v_o) begin
      open_row_r[cur_cmd_r.mem_addr.bank] <= cur_cmd_r.mem_addr.row;
    end
  end

  // back to a word-aligned channel address without the channel index
  assign done_o.write_not_read = cur_cmd_r.write_not_read;
  assign done_o.ch_addr = {
    cur_cmd_r.mem_addr.row,
    cur_cmd_r.mem_addr.bank,
    cur_cmd_r.mem_addr.col,
    {byte_off_width{1'b0}}
  };
  assign done_o.data = cur_cmd_r.data;

endmodule

/* hbm_cmd_queue.sv */
`include "hbm_config.svh"

module hbm_cmd_queue #(
  parameter int depth_p = `HBM_QUEUE_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  push_i,
  input  hbm_req_pkg::hbm_cmd_t push_cmd_i,
  output logic                  full_o,
  input  logic                  pop_i,
  output logic                  head_v_o,
  output hbm_req_pkg::hbm_cmd_t head_cmd_o
);
  import hbm_req_pkg::*;

  localparam int ptr_width = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int count_width = $clog2(depth_p + 1);

  hbm_cmd_t mem_r [depth_p];
  logic [ptr_width-1:0] wr_ptr_r, rd_ptr_r;
  logic [count_width-1:0] count_r;

  assign full_o = (count_r == count_width'(depth_p));
  assign head_v_o = (count_r != '0);
  assign head_cmd_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (push_i && !pop_i) begin
        count_r <= count_r + 1'b1;
      end else if (pop_i && !push_i) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_r[wr_ptr_r] <= push_cmd_i;
    end
  end

endmodule

/* hbm_req_pkg.sv */
package hbm_req_pkg;

  import hbm_addr_pkg::*;

  // request at the top-level port of one channel
  typedef struct packed {
    logic write_not_read;
    hbm_ch_addr_t ch_addr;
  } hbm_req_t;

  // one command queue entry
  typedef struct packed {
    logic write_not_read;
    hbm_mem_addr_t mem_addr;
    hbm_word_t data;
  } hbm_cmd_t;

  // completion handed to the backing store
  typedef struct packed {
    logic write_not_read;
    hbm_ch_addr_t ch_addr;
    hbm_word_t data;
  } hbm_done_t;

endpackage

/* hbm_addr_pkg.sv */
`include "hbm_config.svh"

package hbm_addr_pkg;

  localparam int byte_off_width = $clog2(`HBM_DATA_WIDTH / 8);
  localparam int chan_width = $clog2(`HBM_NUM_CHANNELS);
  localparam int bank_width = $clog2(`HBM_NUM_BANKS);
  localparam int col_width = `HBM_COL_WIDTH;
  localparam int row_width = `HBM_CH_ADDR_WIDTH - byte_off_width - col_width - bank_width;
  localparam int word_addr_width = `HBM_CH_ADDR_WIDTH - byte_off_width;

  typedef logic [`HBM_CH_ADDR_WIDTH-1:0] hbm_ch_addr_t;
  typedef logic [`HBM_DATA_WIDTH-1:0] hbm_word_t;

  typedef logic [row_width-1:0] hbm_row_t;
  typedef logic [bank_width-1:0] hbm_bank_t;
  typedef logic [chan_width-1:0] hbm_chan_t;
  typedef logic [col_width-1:0] hbm_col_t;

  // global address, channel index spliced in above the column
  typedef struct packed {
    hbm_row_t row;
    hbm_bank_t bank;
    hbm_chan_t chan;
    hbm_col_t col;
    logic [byte_off_width-1:0] offset;
  } hbm_mem_addr_t;

endpackage

/* hbm_config.svh */
`ifndef HBM_CONFIG_SVH
`define HBM_CONFIG_SVH

// stack organisation
`define HBM_NUM_CHANNELS 2
`define HBM_NUM_BANKS 4

// per-channel byte address and data word
`define HBM_CH_ADDR_WIDTH 12
`define HBM_DATA_WIDTH 32

// column bits sit just above the byte offset
`define HBM_COL_WIDTH 4

// service latency in cycles
`define HBM_T_HIT 4
`define HBM_T_MISS 10

// command queue entries per channel
`define HBM_QUEUE_DEPTH 4

`endif
